// File: all.f
hw/emesh_pkg.sv
hw/spi_pkg.sv
hw/spi_regs.sv
hw/spi_tx_fifo.sv
hw/spi_baud_timer.sv
hw/spi_fsm.sv
hw/spi_shifter.sv
hw/spi_master.sv
verif/spi_master_sva.sv
verif/spi_master_tb.sv

// File: hw/emesh_pkg.sv
`default_nettype none

package emesh_pkg;

   // ####################
   // packet geometry
   // ####################

   localparam int EMESH_AW = 32;  // address and data width
   localparam int EMESH_PW = 104; // full packet width

   // transfer size field
   typedef enum logic [1:0] {
      DM_BYTE   = 2'b00,
      DM_HALF   = 2'b01,
      DM_WORD   = 2'b10,
      DM_DOUBLE = 2'b11
   } emesh_datamode_e;

   // ####################
   // packet layout, msb first
   // ####################

   typedef struct packed {
      logic                write;    // 1 = write, 0 = read request
      emesh_datamode_e     datamode; // access size
      logic [4:0]          ctrlmode; // routing/side info, echoed back
      logic [EMESH_AW-1:0] dstaddr;  // target address
      logic [EMESH_AW-1:0] data;     // write data or read data
      logic [EMESH_AW-1:0] srcaddr;  // return address for reads
   } emesh_packet_t;

endpackage

`default_nettype wire

// File: hw/spi_baud_timer.sv
`timescale 1ns/1ns
`default_nettype none

module spi_baud_timer (
   input  wire       clk,
   input  wire       nreset,
   input  wire       run,    // from the fsm
   input  wire [7:0] clkdiv, // half-bit period minus one
   output logic      tick
);

   logic [7:0] cnt;

   // ####################
   // half-bit counter
   // ####################

   // reload while stopped so the first tick is a full period away
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         cnt <= '0;
      else if (!run)
         cnt <= clkdiv;
      else if (cnt == 8'd0)
         cnt <= clkdiv; // wrap
      else
         cnt <= cnt - 8'd1;
   end

   assign tick = run & (cnt == 8'd0); // one cycle every clkdiv+1

endmodule

`default_nettype wire

// File: hw/spi_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module spi_fsm (
   input  wire                 clk,
   input  wire                 nreset,
   input  wire                 spi_en,
   input  wire                 fifo_empty,
   input  wire                 tick,
   output spi_pkg::spi_state_e state,
   output logic                run,       // baud timer enable
   output logic                load,      // shifter takes fifo head
   output logic                pop,
   output logic                step,      // one sclk half period
   output logic                rx_access, // byte complete
   output logic                ss_n
);

   import spi_pkg::*;

   spi_state_e state_nxt;
   logic [3:0] bit_cnt; // counts half bits, 16 per byte
   logic       last_tick;

   assign last_tick = tick & (bit_cnt == 4'd15);

   // ####################
   // next state
   // ####################

   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:
            if (spi_en && !fifo_empty)
               state_nxt = SETUP;
         SETUP:
            state_nxt = SHIFT; // single cycle
         SHIFT:
            if (last_tick)
               state_nxt = HOLD;
         HOLD:
            if (tick)
               state_nxt = (spi_en && !fifo_empty) ? SETUP : IDLE; // back to back
         default:
            state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         state     <= IDLE;
         ss_n      <= 1'b1;
         rx_access <= 1'b0;
         bit_cnt   <= '0;
      end
      else
      begin
         state     <= state_nxt;
         ss_n      <= (state_nxt == IDLE); // low across the whole burst
         rx_access <= (state == SHIFT) & last_tick; // first hold cycle
         if (state == SETUP)
            bit_cnt <= '0;
         else if (step)
            bit_cnt <= bit_cnt + 4'd1;
      end
   end

   assign run  = (state == SHIFT) | (state == HOLD);
   assign load = (state == SETUP);
   assign pop  = (state == SETUP);                 // consumed with the load
   assign step = (state == SHIFT) & tick;

endmodule

`default_nettype wire

// File: hw/spi_master.sv
`timescale 1ns/1ns
`default_nettype none

module spi_master #(
   parameter logic [7:0] CLKDIV     = spi_pkg::SPI_DIV_RESET,
   parameter int         FIFO_DEPTH = 8
) (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire                      hw_en,
   input  wire                      access_in,
   input  wire emesh_pkg::emesh_packet_t packet_in,
   output logic                     wait_out,
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out,
   input  wire                      wait_in,    // not honored, response is a pulse
   output logic                     sclk,
   output logic                     mosi,
   input  wire                      miso,
   output logic                     ss_n
);

   import spi_pkg::*;

   spi_cfg_t   cfg;
   spi_state_e spi_state;
   logic       spi_en;
   logic [7:0] clkdiv;
   logic       tx_push;
   logic [7:0] tx_byte;
   logic [7:0] fifo_dout;
   logic       fifo_empty;
   logic       fifo_full;
   logic       run;
   logic       tick;
   logic       load;
   logic       pop;
   logic       step;
   logic       rx_access;
   logic [7:0] rx_byte;

   // ####################
   // bus side
   // ####################

   spi_regs #(.CLKDIV(CLKDIV)) spi_regs_i (
      .clk, .nreset, .hw_en, .access_in, .packet_in, .rx_byte, .rx_access,
      .spi_state, .fifo_full, .cfg, .spi_en, .clkdiv, .tx_push, .tx_byte,
      .wait_out, .access_out, .packet_out
   );

   spi_tx_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) spi_tx_fifo_i (
      .clk, .nreset, .push(tx_push), .din(tx_byte), .pop,
      .dout(fifo_dout), .empty(fifo_empty), .full(fifo_full)
   );

   // ####################
   // serial side
   // ####################

   spi_baud_timer spi_baud_timer_i (.clk, .nreset, .run, .clkdiv, .tick);

   spi_fsm spi_fsm_i (
      .clk, .nreset, .spi_en, .fifo_empty, .tick, .state(spi_state),
      .run, .load, .pop, .step, .rx_access, .ss_n
   );

   spi_shifter spi_shifter_i (
      .clk, .nreset, .cfg, .load, .din(fifo_dout), .step,
      .active(run), .miso, .sclk, .mosi, .rx_byte
   );

endmodule

`default_nettype wire

// File: hw/spi_pkg.sv
`default_nettype none

package spi_pkg;

   // ####################
   // register map
   // ####################

   // offsets within the block, low 6 address bits
   typedef enum logic [5:0] {
      SPI_CONFIG = 6'h00,
      SPI_STATUS = 6'h04,
      SPI_CLKDIV = 6'h08,
      SPI_TX     = 6'h10,
      SPI_RX0    = 6'h18, // newest four bytes
      SPI_RX1    = 6'h1C  // older four bytes
   } spi_addr_e;

   // config register, bit 0 at the bottom
   typedef struct packed {
      logic [2:0] spare;       // stored, no function
      logic       lsbfirst;    // bit 4
      logic       cpha;        // bit 3
      logic       cpol;        // bit 2
      logic       irq_en;      // bit 1, read back only
      logic       spi_disable; // bit 0, block is on by default
   } spi_cfg_t;

   // transfer sequencer states
   typedef enum logic [1:0] {IDLE, SETUP, SHIFT, HOLD} spi_state_e;

   localparam logic [31:0] SPI_BAD_READ  = 32'hDEAD_BEEF; // unmapped reads
   localparam logic [7:0]  SPI_DIV_RESET = 8'd3;          // divider out of reset

endpackage

`default_nettype wire

// File: hw/spi_regs.sv
`timescale 1ns/1ns
`default_nettype none

module spi_regs #(
   parameter logic [7:0] CLKDIV = spi_pkg::SPI_DIV_RESET // divider reset value
) (
   input  wire                      clk,
   input  wire                      nreset,
   input  wire                      hw_en,      // block enable pin
   input  wire                      access_in,
   input  wire emesh_pkg::emesh_packet_t packet_in,
   input  wire [7:0]                rx_byte,    // byte just received
   input  wire                      rx_access,  // one pulse per byte
   input  wire spi_pkg::spi_state_e spi_state,
   input  wire                      fifo_full,
   output spi_pkg::spi_cfg_t        cfg,
   output logic                     spi_en,
   output logic [7:0]               clkdiv,
   output logic                     tx_push,
   output logic [7:0]               tx_byte,
   output logic                     wait_out,
   output logic                     access_out,
   output emesh_pkg::emesh_packet_t packet_out
);

   import emesh_pkg::*;
   import spi_pkg::*;

   spi_addr_e     addr;
   logic          accept;
   logic          reg_write;
   logic          reg_read;
   logic [7:0]    status_q;
   logic [63:0]   rx_q;
   logic [31:0]   rd_data;
   emesh_packet_t resp_q;

   // ####################
   // decode
   // ####################

   // only tx writes stall, so status and config stay reachable while full
   assign wait_out  = fifo_full & access_in & packet_in.write & (addr == SPI_TX);
   assign accept    = access_in & ~wait_out;
   assign reg_write = accept & packet_in.write;
   assign reg_read  = accept & ~packet_in.write;
   assign addr      = spi_addr_e'(packet_in.dstaddr[5:0]);

   // tx bytes go straight into the fifo, same cycle
   assign tx_push = reg_write & (addr == SPI_TX);
   assign tx_byte = packet_in.data[7:0];

   // ####################
   // config, divider, status
   // ####################

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         cfg <= '0;
      else if (reg_write && addr == SPI_CONFIG)
         cfg <= spi_cfg_t'(packet_in.data[7:0]);
   end

   assign spi_en = hw_en & ~cfg.spi_disable;

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         clkdiv <= CLKDIV;
      else if (reg_write && addr == SPI_CLKDIV)
         clkdiv <= packet_in.data[7:0];
   end

   // live bits refresh every cycle, bit 0 is sticky
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         status_q <= '0;
      else if (reg_write && addr == SPI_STATUS)
         status_q <= packet_in.data[7:0];
      else
         status_q <= {5'b0,
                      fifo_full,                   // 2
                      (spi_state != IDLE),         // 1 busy
                      (rx_access | status_q[0])};  // 0 received
   end

   // 64-bit history, newest byte lands at the bottom
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         rx_q <= '0;
      else if (rx_access)
         rx_q <= {rx_q[55:0], rx_byte};
   end

   // ####################
   // read response
   // ####################

   always_comb
   begin
      case (addr)
         SPI_CONFIG: rd_data = {24'b0, cfg};
         SPI_STATUS: rd_data = {24'b0, status_q};
         SPI_CLKDIV: rd_data = {24'b0, clkdiv};
         SPI_RX0:    rd_data = rx_q[31:0];
         SPI_RX1:    rd_data = rx_q[63:32];
         default:    rd_data = SPI_BAD_READ; // includes tx, write-only
      endcase
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         access_out <= 1'b0;
      else
         access_out <= reg_read; // single-cycle pulse
   end

   always_ff @(posedge clk)
   begin
      if (reg_read)
      begin
         resp_q.write    <= 1'b1;
         resp_q.datamode <= packet_in.datamode;
         resp_q.ctrlmode <= packet_in.ctrlmode;
         resp_q.dstaddr  <= packet_in.srcaddr; // return to sender
         resp_q.data     <= rd_data;
         resp_q.srcaddr  <= '0;
      end
   end

   assign packet_out = resp_q;

endmodule

`default_nettype wire

// File: hw/spi_shifter.sv
`timescale 1ns/1ns
`default_nettype none

module spi_shifter (
   input  wire               clk,
   input  wire               nreset,
   input  wire spi_pkg::spi_cfg_t cfg,
   input  wire               load,
   input  wire  [7:0]        din,
   input  wire               step,
   input  wire               active, // transfer in progress
   input  wire               miso,
   output logic              sclk,
   output logic              mosi,
   output logic [7:0]        rx_byte
);

   logic [7:0] tx_q;
   logic       phase;  // 0 before a leading edge, 1 before a trailing one
   logic       mosi_q; // launched on leading edges, cpha=1 only
   logic       tx_bit;
   logic       do_sample;
   logic       do_shift;

   assign tx_bit    = cfg.lsbfirst ? tx_q[0] : tx_q[7];
   assign do_sample = step & active & (phase == cfg.cpha); // cpha swaps order
   assign do_shift  = step & active & (phase != cfg.cpha);

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         phase  <= 1'b0;
         tx_q   <= '0;
         mosi_q <= 1'b0;
      end
      else if (load)
      begin
         phase <= 1'b0;
         tx_q  <= din;
      end
      else
      begin
         if (step && active)
            phase <= ~phase;
         if (do_shift)
         begin
            mosi_q <= tx_bit;
            tx_q   <= cfg.lsbfirst ? {1'b0, tx_q[7:1]} : {tx_q[6:0], 1'b0};
         end
      end
   end

   // same bit order as transmit, so loopback returns the byte unchanged
   always_ff @(posedge clk)
   begin
      if (do_sample)
         rx_byte <= cfg.lsbfirst ? {miso, rx_byte[7:1]} : {rx_byte[6:0], miso};
   end

   assign sclk = cfg.cpol ^ (phase & active); // rests at cpol
   assign mosi = cfg.cpha ? mosi_q : tx_bit;  // cpha=0 presents bit before first edge

endmodule

`default_nettype wire

// File: hw/spi_tx_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module spi_tx_fifo #(
   parameter int FIFO_DEPTH = 8 // power of two
) (
   input  wire        clk,
   input  wire        nreset,
   input  wire        push,
   input  wire  [7:0] din,
   input  wire        pop,
   output logic [7:0] dout,
   output logic       empty,
   output logic       full
);

   localparam int AW = $clog2(FIFO_DEPTH);

   logic [7:0]  mem [FIFO_DEPTH];
   logic [AW:0] wr_ptr; // msb is the wrap bit
   logic [AW:0] rd_ptr;
   logic        do_push;
   logic        do_pop;

   assign do_push = push & ~full;  // drop when full
   assign do_pop  = pop & ~empty;  // ignore when empty

   assign empty = (wr_ptr == rd_ptr);
   assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
   assign dout  = mem[rd_ptr[AW-1:0]]; // head of queue, always visible

   always_ff @(posedge clk)
   begin
      if (do_push)
         mem[wr_ptr[AW-1:0]] <= din;
   end

   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end
      else
      begin
         wr_ptr <= wr_ptr + (AW+1)'(do_push);
         rd_ptr <= rd_ptr + (AW+1)'(do_pop);
      end
   end

endmodule

`default_nettype wire

// File: verif/spi_master_sva.sv
`timescale 1ns/1ns
`default_nettype none

module spi_master_sva (
   input wire                           clk,
   input wire                           nreset,
   input wire                           access_in,
   input wire                           wait_out,
   input wire emesh_pkg::emesh_packet_t packet_in,
   input wire                           access_out,
   input wire spi_pkg::spi_state_e      spi_state,
   input wire spi_pkg::spi_cfg_t        cfg,
   input wire                           ss_n,
   input wire                           sclk
);

   import spi_pkg::*;

   int fail_cnt; // assertion failures so far

   // accepted read gets its pulse on the next cycle
   a_read_resp: assert property (@(posedge clk) disable iff (!nreset)
      access_in && !wait_out && !packet_in.write |=> access_out)
      else
      begin
         $error("read accepted without a response one cycle later");
         fail_cnt++;
      end

   a_idle_ss: assert property (@(posedge clk) disable iff (!nreset)
      spi_state == IDLE |-> ss_n)
      else
      begin
         $error("ss_n low while the FSM is idle");
         fail_cnt++;
      end

   // no edges outside a selected transfer
   a_sclk_rest: assert property (@(posedge clk) disable iff (!nreset)
      ss_n |-> sclk == cfg.cpol)
      else
      begin
         $error("sclk left its idle level while ss_n high");
         fail_cnt++;
      end

endmodule

bind spi_master spi_master_sva spi_master_sva_i (
   .clk, .nreset, .access_in, .wait_out, .packet_in, .access_out,
   .spi_state, .cfg, .ss_n, .sclk
);

`default_nettype wire

// File: verif/spi_master_tb.sv
`timescale 1ns/1ns
`default_nettype none

module spi_master_tb;

   import emesh_pkg::*;
   import spi_pkg::*;

   localparam int MAX_WORDS  = 256;  // four words per test
   localparam int POLL_LIMIT = 1000; // status reads before giving up
   localparam int RESP_LIMIT = 8;    // cycles to wait for a read response

   logic          clk;
   logic          nreset;
   logic          hw_en;
   logic          access_in;
   emesh_packet_t packet_in;
   logic          wait_out;
   logic          access_out;
   emesh_packet_t packet_out;
   logic          wait_in;
   logic          sclk;
   logic          mosi;
   logic          ss_n;

   logic [31:0]   pat [MAX_WORDS]; // kind, addr, data, expected
   int            n_tests;
   int            errors;
   int            passed;
   int            failed;
   int            tx_bytes;   // bytes accepted into the fifo
   int            sclk_edges; // sclk toggles while selected
   logic          sclk_last;

   // mosi looped back into miso
   spi_master spi_master_i (
      .clk, .nreset, .hw_en, .access_in, .packet_in, .wait_out, .access_out,
      .packet_out, .wait_in, .sclk, .mosi, .miso(mosi), .ss_n
   );

   always #4 clk = ~clk; // 8 ns period

   // sclk edges inside selected transfers, sampled mid-cycle
   always @(negedge clk)
   begin
      if (nreset && !ss_n && sclk !== sclk_last)
         sclk_edges++;
      sclk_last = sclk;
   end

   // ####################
   // bus helpers
   // ####################

   function automatic emesh_packet_t build_packet(input logic wr, input logic [5:0] addr,
                                                  input logic [31:0] data);
      emesh_packet_t pkt;
      pkt          = '0;
      pkt.write    = wr;
      pkt.datamode = DM_WORD;
      pkt.dstaddr  = {26'b0, addr};
      pkt.data     = data;
      pkt.srcaddr  = $urandom; // echoed back as dstaddr
      return pkt;
   endfunction

   task automatic idle_gap;
      repeat (2 + $urandom % 4) @(posedge clk); // at least two cycles
   endtask

   // hold the request until wait_out drops, return on the accepting edge
   task automatic send_request(input logic wr, input logic [5:0] addr,
                               input logic [31:0] data, output logic [31:0] src);
      emesh_packet_t pkt;
      pkt       = build_packet(wr, addr, data);
      src       = pkt.srcaddr;
      access_in <= 1'b1;
      packet_in <= pkt;
      @(negedge clk);
      while (wait_out)
         @(negedge clk);
      @(posedge clk);
      access_in <= 1'b0;
   endtask

   task automatic read_reg(input string name, input logic [5:0] addr,
                           output logic [31:0] data);
      logic [31:0] src;
      int          waited;
      send_request(1'b0, addr, 32'h0, src);
      waited = 0;
      @(negedge clk);
      while (!access_out && waited < RESP_LIMIT)
      begin
         @(negedge clk);
         waited++;
      end
      data = packet_out.data;
      assert (access_out)
      else
      begin
         $display("%s: no read response arrived", name);
         errors++;
      end
      assert (packet_out.dstaddr == src) // response goes back to the requester
      else
      begin
         $display("error %s dstaddr expected %08h actual %08h", name, src, packet_out.dstaddr);
         errors++;
      end
   endtask

   // a tx write that must stay blocked while the fifo is full
   task automatic hold_refused(input string name, input logic [5:0] addr,
                               input logic [31:0] data, input int cycles);
      int n;
      access_in <= 1'b1;
      packet_in <= build_packet(1'b1, addr, data);
      for (n = 0; n < cycles; n++)
      begin
         @(negedge clk);
         assert (wait_out)
         else
         begin
            $display("error %s wait_out expected 1 actual 0", name);
            errors++;
         end
      end
      @(posedge clk);
      access_in <= 1'b0; // withdraw
   endtask

   // ####################
   // test sequence
   // ####################

   initial
   begin
      logic [31:0] kind;
      logic [31:0] addr;
      logic [31:0] data;
      logic [31:0] exp_v;
      logic [31:0] got;
      logic [31:0] src;
      int          i;
      int          polls;
      int          err_before;
      string       name;

      clk       = 1'b0;
      nreset    = 1'b0;
      hw_en     = 1'b1;
      access_in = 1'b0;
      packet_in = '0;
      wait_in   = 1'b0; // responses are pulses, never stalled
      errors    = 0;
      passed    = 0;
      failed    = 0;
      tx_bytes  = 0;
      void'($urandom(32'h33c9_0241));

      for (i = 0; i < MAX_WORDS; i++)
         pat[i] = '0; // kind 0 marks the end
      $readmemh("verif/spi_patterns.txt", pat);
      n_tests = 0;
      while (4 * n_tests < MAX_WORDS && pat[4 * n_tests] != 0)
         n_tests++;
      if (n_tests == 0)
      begin
         $display("no tests found in the pattern file");
         errors++;
      end

      repeat (8) @(posedge clk);
      nreset <= 1'b1;

      for (i = 0; i < n_tests; i++)
      begin
         kind       = pat[4 * i];
         addr       = pat[4 * i + 1];
         data       = pat[4 * i + 2];
         exp_v      = pat[4 * i + 3];
         name       = $sformatf("test %0d kind %0d addr %02h", i, kind, addr[7:0]);
         err_before = errors;
         idle_gap();
         case (kind)
            1:
            begin
               send_request(1'b1, addr[5:0], data, src);
               if (addr[5:0] == SPI_TX)
                  tx_bytes++;
            end
            2:
            begin
               read_reg(name, addr[5:0], got);
               assert (got == exp_v)
               else
               begin
                  $display("error %s expected %08h actual %08h", name, exp_v, got);
                  errors++;
               end
            end
            3:
            begin
               // poll busy until the fsm is back in idle
               polls = 0;
               got   = 32'h2;
               while (got[1] && polls < POLL_LIMIT)
               begin
                  read_reg(name, SPI_STATUS, got);
                  polls++;
                  if (got[1])
                     idle_gap();
               end
               assert (!got[1])
               else
               begin
                  $display("%s: transfer still busy after %0d status reads", name, polls);
                  errors++;
               end
               assert (sclk_edges == 16 * tx_bytes) // two edges per bit
               else
               begin
                  $display("error %s sclk edges expected %0d actual %0d", name,
                           16 * tx_bytes, sclk_edges);
                  errors++;
               end
            end
            4: hold_refused(name, addr[5:0], data, exp_v);
            5: hw_en <= data[0];
            6:
            begin
               @(negedge clk);
               assert (ss_n == exp_v[0])
               else
               begin
                  $display("error %s ss_n expected %0d actual %0d", name, exp_v[0], ss_n);
                  errors++;
               end
            end
            default:
            begin
               $display("%s: unknown operation kind in the pattern file", name);
               errors++;
            end
         endcase
         if (errors == err_before)
         begin
            passed++;
            $display("%s passed", name);
         end
         else
         begin
            failed++;
            $display("%s failed", name);
         end
      end

      if (spi_master_i.spi_master_sva_i.fail_cnt != 0)
      begin
         $display("bound assertions on the DUT failed %0d times",
                  spi_master_i.spi_master_sva_i.fail_cnt);
         errors += spi_master_i.spi_master_sva_i.fail_cnt;
      end

      $display("tests %0d passed %0d failed %0d errors %0d", n_tests, passed, failed, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

   // watchdog, sized from the number of tests
   initial
   begin
      wait (n_tests > 0);
      #(n_tests * 16 * 256 * 8);
      $display("timeout: the tests did not finish in time");
      $display(">>> FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: verif/spi_patterns.txt
// each line holds kind addr data expected in hex
// kind 1 write 2 read 3 wait for idle 4 refused write 5 set hw_en 6 check ss_n 0 end
2 00 00000000 00000000 // config out of reset
2 08 00000000 00000003 // divider reset value
2 04 00000000 00000000
2 0C 00000000 DEADBEEF // unmapped offset
1 00 000000E2 00000000 // spare and irq_en bits
2 00 00000000 000000E2
1 08 00000001 00000000 // faster sclk
2 08 00000000 00000001
1 00 00000000 00000000 // mode 0 msb first
1 10 000000A5 00000000
2 04 00000000 00000002 // busy mid transfer
3 04 00000000 00000000
2 04 00000000 00000001 // received bit set
1 04 00000000 00000000
2 04 00000000 00000000
1 00 00000018 00000000 // cpha lsb first
1 10 0000003C 00000000
3 04 00000000 00000000
1 00 00000014 00000000 // cpol lsb first
1 10 00000081 00000000
3 04 00000000 00000000
1 00 0000000C 00000000 // cpol cpha msb first
1 10 0000005E 00000000
3 04 00000000 00000000
2 18 00000000 A53C815E
2 1C 00000000 00000000
1 00 00000001 00000000 // disabled so bytes pile up
1 10 00000011 00000000
1 10 00000022 00000000
1 10 00000033 00000000
1 10 00000044 00000000
1 10 00000055 00000000
1 10 00000066 00000000
1 10 00000077 00000000
1 10 00000088 00000000
4 10 00000099 00000004 // ninth byte held off for 4 cycles
2 04 00000000 00000005 // full and received
1 00 00000000 00000000 // enable and drain
3 04 00000000 00000000
2 1C 00000000 11223344
2 18 00000000 55667788
5 00 00000000 00000000 // hw_en low
1 10 00000099 00000000
2 04 00000000 00000001 // still idle
6 00 00000000 00000001
5 00 00000001 00000000 // hw_en back on
3 04 00000000 00000000
2 18 00000000 66778899
0 00 00000000 00000000
